// File: rename_core.f
src/core_cfg_pkg.sv
src/core_types_pkg.sv
src/issue_ctrl.sv
src/rename_regfile.sv
src/reorder_buffer.sv
src/operand_bypass.sv
src/rename_core.sv
sim/rename_core_props.sv
sim/rename_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rename_core_tb -Mdir obj_dir -f rename_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrename_core_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
echo "No pass line found in sim.log"
exit 1

// File: sim/rename_core_props.sv
module rename_core_props (
    input logic clk_in,
    input logic rob_regfile_rst_in,
    input logic issue_valid,
    input logic flush,
    input logic full,
    input logic head_ready,
    input logic issue_fire,
    input logic issue_stall,
    input logic rob_alloc
);

    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Issue and commit arbitration
    // ==============================

    a_fire_not_stall : assert property (@(posedge clk_in) disable iff (rob_regfile_rst_in)
        !(issue_fire && issue_stall))
        else $error("issue_fire and issue_stall are high in the same cycle");

    a_stall_held : assert property (@(posedge clk_in) disable iff (rob_regfile_rst_in)
        issue_stall |=> issue_valid)
        else $error("A stalled issue was dropped before it fired");

    a_full_after_alloc : assert property (@(posedge clk_in) disable iff (rob_regfile_rst_in)
        $rose(full) |-> $past(rob_alloc))
        else $error("Buffer became full without an allocation");

    a_flush_empties : assert property (@(posedge clk_in) disable iff (rob_regfile_rst_in)
        flush |=> (!full && !head_ready))
        else $error("Buffer still holds entries after a flush");

endmodule : rename_core_props

bind issue_ctrl rename_core_props u_props (
    .clk_in             (clk_in),
    .rob_regfile_rst_in (rob_regfile_rst_in),
    .issue_valid        (issue_valid),
    .flush              (flush),
    .full               (full),
    .head_ready         (head_ready),
    .issue_fire         (issue_fire),
    .issue_stall        (issue_stall),
    .rob_alloc          (rob_alloc)
);

// File: sim/rename_core_tb.sv
module rename_core_tb
    import core_cfg_pkg::*, core_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_steps    = 24;
    localparam int hold_limit = 20;               // Cycles an issue may stall.
    localparam int drain_limit = 40;

    typedef struct packed {
        logic             iv;
        logic             rd_en;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic             wv;
        logic [rob_w-1:0] wtag;
        logic             fl;
    } step_t;

    logic             clk_in;
    logic             rob_regfile_rst_in;
    logic             issue_valid;
    logic             issue_rd_en;
    logic [reg_w-1:0] issue_rd;
    logic [reg_w-1:0] issue_rs;
    logic [reg_w-1:0] issue_rt;
    logic             wb_valid;
    logic [rob_w-1:0] wb_tag;
    logic [xlen-1:0]  wb_value;
    logic             flush;
    logic             issue_fire;
    logic             issue_stall;
    logic [rob_w-1:0] issue_tag;
    logic             rs_ready;
    operand_u         rs_operand;
    logic             rt_ready;
    operand_u         rt_operand;
    logic             commit_valid;
    logic             commit_rd_en;
    logic [reg_w-1:0] commit_rd;
    logic [xlen-1:0]  commit_value;

    // Reference model state.
    logic [xlen-1:0]  m_arch  [reg_count];
    logic             m_busy  [reg_count];
    logic [rob_w-1:0] m_map   [reg_count];
    logic             m_rdy   [rob_depth];
    logic [xlen-1:0]  m_val   [rob_depth];
    logic             m_rd_en [rob_depth];
    logic [reg_w-1:0] m_rd    [rob_depth];
    logic [rob_w-1:0] m_head;
    logic [rob_w-1:0] m_tail;
    int               m_count;
    integer           seed;
    step_t            steps [n_steps];

    rename_core u_dut (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        if (got_v !== exp_v) begin
            $display("ERROR %s expected %h got %h", name, exp_v, got_v);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Simulation failed");
        $fatal(1, "Wait limit reached");
    endtask

    // Value if known from regfile, ROB or live writeback, else producer tag.
    function automatic operand_u model_operand(input logic [reg_w-1:0] r, input logic wv,
        input logic [rob_w-1:0] wtag, input logic [xlen-1:0] wval, output logic ready);
        operand_u         op;
        logic [rob_w-1:0] t;
        op    = '0;
        t     = m_map[r];
        ready = 1'b1;
        if (!m_busy[r]) begin
            op.value = m_arch[r];
        end else if (m_rdy[t]) begin
            op.value = m_val[t];
        end else if (wv && (wtag == t)) begin
            op.value = wval;
        end else begin
            ready     = 1'b0;
            op.tag.id = t;
        end
        return op;
    endfunction

    task automatic run_cycle(input logic iv, input logic rd_en, input logic [reg_w-1:0] rd,
        input logic [reg_w-1:0] rs, input logic [reg_w-1:0] rt, input logic wv,
        input logic [rob_w-1:0] wtag, input logic [xlen-1:0] wval, input logic fl,
        output logic fired);
        logic     full;
        logic     fire;
        logic     stall;
        logic     cv;
        logic     rs_rdy;
        logic     rt_rdy;
        operand_u rs_op;
        operand_u rt_op;
        @(posedge clk_in);
        issue_valid <= iv;
        issue_rd_en <= rd_en;
        issue_rd    <= rd;
        issue_rs    <= rs;
        issue_rt    <= rt;
        wb_valid    <= wv;
        wb_tag      <= wtag;
        wb_value    <= wval;
        flush       <= fl;
        @(negedge clk_in);
        full  = (m_count == rob_depth);
        fire  = iv && !full && !fl;
        stall = iv && full;
        cv    = (m_count != 0) && m_rdy[m_head] && !fl;
        rs_op = model_operand(rs, wv, wtag, wval, rs_rdy);
        rt_op = model_operand(rt, wv, wtag, wval, rt_rdy);
        check_value("issue_fire", 32'(fire), 32'(issue_fire));
        check_value("issue_stall", 32'(stall), 32'(issue_stall));
        check_value("commit_valid", 32'(cv), 32'(commit_valid));
        check_value("rs_ready", 32'(rs_rdy), 32'(rs_ready));
        check_value("rs_operand", rs_op, rs_operand);
        check_value("rt_ready", 32'(rt_rdy), 32'(rt_ready));
        check_value("rt_operand", rt_op, rt_operand);
        if (iv) begin
            check_value("issue_tag", 32'(m_tail), 32'(issue_tag));
        end
        if (cv) begin
            check_value("commit_rd_en", 32'(m_rd_en[m_head]), 32'(commit_rd_en));
            check_value("commit_rd", 32'(m_rd[m_head]), 32'(commit_rd));
            check_value("commit_value", m_val[m_head], commit_value);
            if (m_rd_en[m_head] && (m_rd[m_head] != '0)) begin
                m_arch[m_rd[m_head]] = m_val[m_head];
                if (m_map[m_rd[m_head]] == m_head) begin
                    m_busy[m_rd[m_head]] = 1'b0;   // Youngest writer retired.
                end
            end
            m_head++;
            m_count--;
        end
        if (wv) begin
            m_rdy[wtag] = 1'b1;
            m_val[wtag] = wval;
        end
        if (fire) begin
            m_rdy[m_tail]   = 1'b0;
            m_rd_en[m_tail] = rd_en;
            m_rd[m_tail]    = rd;
            if (rd_en && (rd != '0)) begin
                m_busy[rd] = 1'b1;                 // Rename beats commit clear.
                m_map[rd]  = m_tail;
            end
            m_tail++;
            m_count++;
        end
        if (fl) begin
            for (int i = 0; i < reg_count; i++) begin
                m_busy[i] = 1'b0;
            end
            m_head  = '0;
            m_tail  = '0;
            m_count = 0;
        end
        fired = fire;
    endtask

    task automatic apply_step(input int s);
        logic            fired;
        int              waited;
        logic [xlen-1:0] wval;
        waited = 0;
        wval   = 32'(steps[s].wtag) * 32'h0101_0101 + 32'(s);
        run_cycle(steps[s].iv, steps[s].rd_en, steps[s].rd, steps[s].rs, steps[s].rt,
                  steps[s].wv, steps[s].wtag, wval, steps[s].fl, fired);
        while (steps[s].iv && !fired) begin        // Hold until accepted.
            if (waited == hold_limit) begin
                report_timeout($sformatf("step %0d was never accepted", s));
            end
            run_cycle(1'b1, steps[s].rd_en, steps[s].rd, steps[s].rs, steps[s].rt,
                      1'b0, '0, '0, 1'b0, fired);
            waited++;
        end
    endtask

    initial begin
        logic fired;
        int   gap;
        int   waited;
        seed  = 32'h552f_f7e6;
        //        iv    rd_en rd     rs     rt     wv    wtag  fl
        steps = '{'{1'b1, 1'b1, 5'd1,  5'd2,  5'd3,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd2,  5'd1,  5'd1,  1'b0, 3'd0, 1'b0},  // Waits on tag 0.
                  '{1'b1, 1'b1, 5'd3,  5'd1,  5'd2,  1'b1, 3'd0, 1'b0},  // Live bypass.
                  '{1'b1, 1'b1, 5'd4,  5'd2,  5'd3,  1'b1, 3'd2, 1'b0},
                  '{1'b0, 1'b0, 5'd0,  5'd1,  5'd4,  1'b1, 3'd3, 1'b0},  // Out of order.
                  '{1'b0, 1'b0, 5'd0,  5'd2,  5'd3,  1'b1, 3'd1, 1'b0},
                  '{1'b1, 1'b1, 5'd0,  5'd1,  5'd4,  1'b0, 3'd0, 1'b0},  // Write to r0.
                  '{1'b0, 1'b0, 5'd0,  5'd0,  5'd0,  1'b1, 3'd4, 1'b0},
                  '{1'b1, 1'b0, 5'd5,  5'd0,  5'd3,  1'b0, 3'd0, 1'b0},
                  '{1'b0, 1'b0, 5'd0,  5'd4,  5'd5,  1'b1, 3'd5, 1'b0},
                  '{1'b0, 1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd6,  5'd5,  5'd4,  1'b0, 3'd0, 1'b0},  // Fill the ROB.
                  '{1'b1, 1'b1, 5'd7,  5'd6,  5'd1,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd8,  5'd7,  5'd2,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd9,  5'd8,  5'd3,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd10, 5'd9,  5'd4,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd11, 5'd10, 5'd5,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd12, 5'd11, 5'd6,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd13, 5'd12, 5'd7,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd14, 5'd13, 5'd6,  1'b1, 3'd6, 1'b0},  // Stalls first.
                  '{1'b0, 1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 3'd0, 1'b1},  // Flush.
                  '{1'b1, 1'b1, 5'd7,  5'd6,  5'd8,  1'b0, 3'd0, 1'b0},
                  '{1'b1, 1'b1, 5'd8,  5'd7,  5'd1,  1'b1, 3'd0, 1'b0},
                  '{1'b0, 1'b0, 5'd0,  5'd8,  5'd7,  1'b1, 3'd1, 1'b0}};
        rob_regfile_rst_in = 1'b1;
        issue_valid = 1'b0;
        issue_rd_en = 1'b0;
        issue_rd    = '0;
        issue_rs    = '0;
        issue_rt    = '0;
        wb_valid    = 1'b0;
        wb_tag      = '0;
        wb_value    = '0;
        flush       = 1'b0;
        for (int i = 0; i < reg_count; i++) begin
            m_arch[i] = '0;
            m_busy[i] = 1'b0;
            m_map[i]  = '0;
        end
        for (int i = 0; i < rob_depth; i++) begin
            m_rdy[i] = 1'b0;
        end
        m_head       = '0;
        m_tail       = '0;
        m_count      = 0;
        repeat (8) @(posedge clk_in);
        rob_regfile_rst_in <= 1'b0;

        // ==============================
        // Reset state and stimulus table
        // ==============================

        for (int i = 0; i < reg_count / 2; i++) begin
            run_cycle(1'b0, 1'b0, '0, reg_w'(2 * i), reg_w'(2 * i + 1), 1'b0, '0, '0, 1'b0,
                      fired);
        end
        for (int s = 0; s < n_steps; s++) begin
            apply_step(s);
            gap = $unsigned($random(seed)) % 3;    // Random idle gap.
            repeat (gap) run_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0, fired);
        end
        waited = 0;
        while (m_count != 0) begin
            if (waited == drain_limit) begin
                report_timeout("reorder buffer did not drain");
            end
            run_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0, fired);
            waited++;
        end
        $display("Simulation passed");
        $finish;
    end

endmodule : rename_core_tb

// File: src/core_cfg_pkg.sv
package core_cfg_pkg;

    // ==============================
    // Datapath
    // ==============================

    localparam int xlen = 32;                      // Data word width.

    // ==============================
    // Architectural registers
    // ==============================

    localparam int reg_count = 32;
    localparam int reg_w     = $clog2(reg_count);  // Register index width.

    // ==============================
    // Reorder buffer
    // ==============================

    // Depth stays a power of two so head and tail wrap on their own.
    localparam int rob_depth = 8;
    localparam int rob_w     = $clog2(rob_depth);  // Tag width.

endpackage : core_cfg_pkg

// File: src/core_types_pkg.sv
package core_types_pkg;

    import core_cfg_pkg::*;

    // ==============================
    // Operand word
    // ==============================

    // One word with two readings. The ready bit that travels beside it
    // picks the view: value when ready, producer tag when not.
    typedef union packed {
        logic [xlen-1:0] value;                 // Resolved operand.
        struct packed {
            logic [xlen-rob_w-1:0] pad;         // Zero in the tag view.
            logic [rob_w-1:0]      id;          // Producing ROB entry.
        } tag;
    } operand_u;

endpackage : core_types_pkg

// File: src/issue_ctrl.sv
module issue_ctrl (
    input  logic clk_in,
    input  logic rob_regfile_rst_in,
    input  logic issue_valid,
    input  logic flush,
    input  logic full,
    input  logic head_ready,
    output logic issue_fire,
    output logic issue_stall,
    output logic rob_alloc,
    output logic rob_commit,
    output logic flush_all
);

    // ==============================
    // Issue and commit arbitration
    // ==============================

    assign issue_fire  = issue_valid && !full && !flush;
    assign issue_stall = issue_valid && full;      // Hold until space.
    assign rob_alloc   = issue_fire;

    assign rob_commit  = head_ready && !flush;     // Flush wins.
    assign flush_all   = flush;

endmodule : issue_ctrl

// File: src/operand_bypass.sv
module operand_bypass
    import core_cfg_pkg::*, core_types_pkg::*;
(
    input  logic             rs_reg_busy,
    input  logic [rob_w-1:0] rs_reg_tag,
    input  logic [xlen-1:0]  rs_reg_value,
    input  logic             rs_rob_ready,
    input  logic [xlen-1:0]  rs_rob_value,
    input  logic             rt_reg_busy,
    input  logic [rob_w-1:0] rt_reg_tag,
    input  logic [xlen-1:0]  rt_reg_value,
    input  logic             rt_rob_ready,
    input  logic [xlen-1:0]  rt_rob_value,
    input  logic             wb_en,
    input  logic [rob_w-1:0] wb_tag,
    input  logic [xlen-1:0]  wb_value,
    output logic [rob_w-1:0] qa_tag,
    output logic [rob_w-1:0] qb_tag,
    output logic             rs_ready,
    output logic             rt_ready,
    output operand_u         rs_operand,
    output operand_u         rt_operand
);

    // Priority: register file, then ROB entry, then live writeback.
    function automatic void resolve(
        input  logic             busy,
        input  logic [rob_w-1:0] tag,
        input  logic [xlen-1:0]  reg_value,
        input  logic             rob_ready,
        input  logic [xlen-1:0]  rob_value,
        input  logic             fwd_en,
        input  logic [rob_w-1:0] fwd_tag,
        input  logic [xlen-1:0]  fwd_value,
        output logic             ready,
        output operand_u         op
    );
        op    = '0;
        ready = 1'b1;
        if (!busy) begin
            op.value = reg_value;
        end else if (rob_ready) begin
            op.value = rob_value;
        end else if (fwd_en && (fwd_tag == tag)) begin
            op.value = fwd_value;                  // Same-cycle bypass.
        end else begin
            ready    = 1'b0;
            op.tag.id = tag;
        end
    endfunction

    assign qa_tag = rs_reg_tag;
    assign qb_tag = rt_reg_tag;

    always_comb begin
        resolve(rs_reg_busy, rs_reg_tag, rs_reg_value, rs_rob_ready, rs_rob_value,
                wb_en, wb_tag, wb_value, rs_ready, rs_operand);
        resolve(rt_reg_busy, rt_reg_tag, rt_reg_value, rt_rob_ready, rt_rob_value,
                wb_en, wb_tag, wb_value, rt_ready, rt_operand);
    end

endmodule : operand_bypass

// File: src/rename_core.sv
module rename_core
    import core_cfg_pkg::*, core_types_pkg::*;
(
    input  logic             clk_in,
    input  logic             rob_regfile_rst_in,
    input  logic             issue_valid,
    input  logic             issue_rd_en,
    input  logic [reg_w-1:0] issue_rd,
    input  logic [reg_w-1:0] issue_rs,
    input  logic [reg_w-1:0] issue_rt,
    input  logic             wb_valid,
    input  logic [rob_w-1:0] wb_tag,
    input  logic [xlen-1:0]  wb_value,
    input  logic             flush,
    output logic             issue_fire,
    output logic             issue_stall,
    output logic [rob_w-1:0] issue_tag,
    output logic             rs_ready,
    output operand_u         rs_operand,
    output logic             rt_ready,
    output operand_u         rt_operand,
    output logic             commit_valid,
    output logic             commit_rd_en,
    output logic [reg_w-1:0] commit_rd,
    output logic [xlen-1:0]  commit_value
);

    logic             rob_alloc;
    logic             flush_all;
    logic             rob_full;
    logic             head_ready;
    logic [rob_w-1:0] head_tag;
    logic             rename_en;
    logic             reg_commit_en;
    logic             rs_reg_busy;
    logic             rt_reg_busy;
    logic [rob_w-1:0] rs_reg_tag;
    logic [rob_w-1:0] rt_reg_tag;
    logic [xlen-1:0]  rs_reg_value;
    logic [xlen-1:0]  rt_reg_value;
    logic [rob_w-1:0] qa_tag;
    logic [rob_w-1:0] qb_tag;
    logic             qa_ready;
    logic             qb_ready;
    logic [xlen-1:0]  qa_value;
    logic [xlen-1:0]  qb_value;

    assign rename_en     = rob_alloc && issue_rd_en;
    assign reg_commit_en = commit_valid && commit_rd_en;  // Skip no-dest ops.

    issue_ctrl u_ctrl (
        .clk_in             (clk_in),
        .rob_regfile_rst_in (rob_regfile_rst_in),
        .issue_valid        (issue_valid),
        .flush              (flush),
        .full               (rob_full),
        .head_ready         (head_ready),
        .issue_fire         (issue_fire),
        .issue_stall        (issue_stall),
        .rob_alloc          (rob_alloc),
        .rob_commit         (commit_valid),
        .flush_all          (flush_all)
    );

    rename_regfile u_regfile (
        .clk_in             (clk_in),
        .rob_regfile_rst_in (rob_regfile_rst_in),
        .flush_all          (flush_all),
        .rs_addr            (issue_rs),
        .rt_addr            (issue_rt),
        .rs_value           (rs_reg_value),
        .rt_value           (rt_reg_value),
        .rs_busy            (rs_reg_busy),
        .rt_busy            (rt_reg_busy),
        .rs_tag             (rs_reg_tag),
        .rt_tag             (rt_reg_tag),
        .rename_en          (rename_en),
        .rename_rd          (issue_rd),
        .rename_tag         (issue_tag),
        .commit_en          (reg_commit_en),
        .commit_rd          (commit_rd),
        .commit_tag         (head_tag),
        .commit_value       (commit_value)
    );

    reorder_buffer u_rob (
        .clk_in             (clk_in),
        .rob_regfile_rst_in (rob_regfile_rst_in),
        .flush_all          (flush_all),
        .alloc_en           (rob_alloc),
        .alloc_rd_en        (issue_rd_en),
        .alloc_rd           (issue_rd),
        .alloc_tag          (issue_tag),
        .full               (rob_full),
        .wb_en              (wb_valid),
        .wb_tag             (wb_tag),
        .wb_value           (wb_value),
        .commit_en          (commit_valid),
        .head_ready         (head_ready),
        .head_rd_en         (commit_rd_en),
        .head_rd            (commit_rd),
        .head_tag           (head_tag),
        .head_value         (commit_value),
        .qa_tag             (qa_tag),
        .qb_tag             (qb_tag),
        .qa_ready           (qa_ready),
        .qb_ready           (qb_ready),
        .qa_value           (qa_value),
        .qb_value           (qb_value)
    );

    operand_bypass u_bypass (
        .rs_reg_busy  (rs_reg_busy),
        .rs_reg_tag   (rs_reg_tag),
        .rs_reg_value (rs_reg_value),
        .rs_rob_ready (qa_ready),
        .rs_rob_value (qa_value),
        .rt_reg_busy  (rt_reg_busy),
        .rt_reg_tag   (rt_reg_tag),
        .rt_reg_value (rt_reg_value),
        .rt_rob_ready (qb_ready),
        .rt_rob_value (qb_value),
        .wb_en        (wb_valid),
        .wb_tag       (wb_tag),
        .wb_value     (wb_value),
        .qa_tag       (qa_tag),
        .qb_tag       (qb_tag),
        .rs_ready     (rs_ready),
        .rt_ready     (rt_ready),
        .rs_operand   (rs_operand),
        .rt_operand   (rt_operand)
    );

endmodule : rename_core

// File: src/rename_regfile.sv
module rename_regfile
    import core_cfg_pkg::*;
(
    input  logic             clk_in,
    input  logic             rob_regfile_rst_in,
    input  logic             flush_all,
    input  logic [reg_w-1:0] rs_addr,
    input  logic [reg_w-1:0] rt_addr,
    output logic [xlen-1:0]  rs_value,
    output logic [xlen-1:0]  rt_value,
    output logic             rs_busy,
    output logic             rt_busy,
    output logic [rob_w-1:0] rs_tag,
    output logic [rob_w-1:0] rt_tag,
    input  logic             rename_en,
    input  logic [reg_w-1:0] rename_rd,
    input  logic [rob_w-1:0] rename_tag,
    input  logic             commit_en,
    input  logic [reg_w-1:0] commit_rd,
    input  logic [rob_w-1:0] commit_tag,
    input  logic [xlen-1:0]  commit_value
);

    logic [xlen-1:0]  value_q [reg_count];         // Committed values.
    logic             busy_q  [reg_count];
    logic [rob_w-1:0] tag_q   [reg_count];         // Pending producer.

    logic rename_hit;
    logic commit_hit;

    // Register 0 is hardwired, so writes to it are dropped here.
    assign rename_hit = rename_en && (rename_rd != '0);
    assign commit_hit = commit_en && (commit_rd != '0);

    // ==============================
    // Committed state
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rob_regfile_rst_in) begin
            for (int i = 0; i < reg_count; i++) begin
                value_q[i] <= '0;
            end
        end else if (commit_hit) begin
            value_q[commit_rd] <= commit_value;
        end
    end

    // ==============================
    // Rename state
    // ==============================

    // A rename issued in the same cycle is written last and keeps the
    // register busy under its new tag.
    always_ff @(posedge clk_in) begin
        if (rob_regfile_rst_in || flush_all) begin
            for (int i = 0; i < reg_count; i++) begin
                busy_q[i] <= 1'b0;
                tag_q[i]  <= '0;
            end
        end else begin
            if (commit_hit && (tag_q[commit_rd] == commit_tag)) begin
                busy_q[commit_rd] <= 1'b0;         // Last writer retired.
            end
            if (rename_hit) begin
                busy_q[rename_rd] <= 1'b1;
                tag_q[rename_rd]  <= rename_tag;
            end
        end
    end

    assign rs_value = value_q[rs_addr];
    assign rs_busy  = busy_q[rs_addr];
    assign rs_tag   = tag_q[rs_addr];
    assign rt_value = value_q[rt_addr];
    assign rt_busy  = busy_q[rt_addr];
    assign rt_tag   = tag_q[rt_addr];

endmodule : rename_regfile

// File: src/reorder_buffer.sv
module reorder_buffer
    import core_cfg_pkg::*;
(
    input  logic             clk_in,
    input  logic             rob_regfile_rst_in,
    input  logic             flush_all,
    input  logic             alloc_en,
    input  logic             alloc_rd_en,
    input  logic [reg_w-1:0] alloc_rd,
    output logic [rob_w-1:0] alloc_tag,
    output logic             full,
    input  logic             wb_en,
    input  logic [rob_w-1:0] wb_tag,
    input  logic [xlen-1:0]  wb_value,
    input  logic             commit_en,
    output logic             head_ready,
    output logic             head_rd_en,
    output logic [reg_w-1:0] head_rd,
    output logic [rob_w-1:0] head_tag,
    output logic [xlen-1:0]  head_value,
    input  logic [rob_w-1:0] qa_tag,
    input  logic [rob_w-1:0] qb_tag,
    output logic             qa_ready,
    output logic             qb_ready,
    output logic [xlen-1:0]  qa_value,
    output logic [xlen-1:0]  qb_value
);

    logic             rd_en_q [rob_depth];
    logic [reg_w-1:0] rd_q    [rob_depth];
    logic [xlen-1:0]  value_q [rob_depth];
    logic             ready_q [rob_depth];         // Result written back.

    logic [rob_w-1:0] head_q;
    logic [rob_w-1:0] tail_q;
    logic [rob_w:0]   count_q;                     // One extra bit for full.

    // ==============================
    // Queue pointers
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rob_regfile_rst_in || flush_all) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_en, commit_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;       // Both or neither.
            endcase
        end
    end

    // ==============================
    // Entry state
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rob_regfile_rst_in) begin
            for (int i = 0; i < rob_depth; i++) begin
                ready_q[i] <= 1'b0;
            end
        end else begin
            if (wb_en) begin
                ready_q[wb_tag] <= 1'b1;
            end
            if (alloc_en) begin
                ready_q[tail_q] <= 1'b0;           // Fresh entry waits.
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc_en) begin
            rd_en_q[tail_q] <= alloc_rd_en;
            rd_q[tail_q]    <= alloc_rd;
        end
        if (wb_en) begin
            value_q[wb_tag] <= wb_value;
        end
    end

    assign alloc_tag  = tail_q;
    assign full       = (count_q == (rob_w + 1)'(rob_depth));
    assign head_ready = (count_q != '0) && ready_q[head_q];
    assign head_rd_en = rd_en_q[head_q];
    assign head_rd    = rd_q[head_q];
    assign head_tag   = head_q;
    assign head_value = value_q[head_q];

    assign qa_ready = ready_q[qa_tag];
    assign qa_value = value_q[qa_tag];
    assign qb_ready = ready_q[qb_tag];
    assign qb_value = value_q[qb_tag];

endmodule : reorder_buffer
